// ==== filelist.f ====
+incdir+.
bip_isa_pkg.sv
bip_bus_pkg.sv
instruction_decoder.sv
bip_core.sv
bip_bus_arbiter.sv
bip_memory.sv
bip_top.sv
bip_top_sva.sv
tb_bip_top.sv

// ==== Bender.yml ====
package:
  name: bip

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bip_isa_pkg.sv
      - bip_bus_pkg.sv
      - instruction_decoder.sv
      - bip_core.sv
      - bip_bus_arbiter.sv
      - bip_memory.sv
      - bip_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bip_top_sva.sv
      - tb_bip_top.sv

// ==== tb_bip_top.sv ====
`default_nettype none

`include "bip_settings.svh"

module tb_bip_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned HOST_TIMEOUT = 64;              // Cycles per host handshake
    localparam int unsigned RUN_TIMEOUT  = 20000;           // Cycles per program run
    localparam int unsigned MODEL_STEPS  = 4096;            // Model gives up after this
    localparam logic [`BIP_OPERAND_W-1:0] DATA_BASE = 11'h400;  // Program data region
    localparam logic [`BIP_OPERAND_W-1:0] HOST_BASE = 11'h700;  // Host-only region

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_start;
    logic                   o_busy;
    logic [`BIP_DATA_W-1:0] o_acc;
    bip_bus_pkg::wb_req_t   i_host_req;
    bip_bus_pkg::wb_rsp_t   o_host_rsp;

    logic [`BIP_DATA_W-1:0] shadow [`BIP_MEM_DEPTH];        // Expected memory image
    logic [`BIP_DATA_W-1:0] model_acc;                      // Expected accumulator
    logic [`BIP_DATA_W-1:0] prog_q [$];                     // Program under test
    logic [31:0]            rng_state = 32'h1e116691;
    int unsigned            value_errors;
    int unsigned            timeout_errors;

    bip_top u_bip_top
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .o_busy     (o_busy),
        .o_acc      (o_acc),
        .i_host_req (i_host_req),
        .o_host_rsp (o_host_rsp)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;                          // 40 ns period
    end

    ////////////////////////////////////////////////////////////
    // Random numbers, encoding and compares
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Opcode above operand
    function automatic logic [`BIP_DATA_W-1:0] encode(input logic [`BIP_OPCODE_W-1:0] op,
                                                      input logic [`BIP_OPERAND_W-1:0] operand);
        return {op, operand};
    endfunction

    task automatic check_word(input string name, input logic [`BIP_DATA_W-1:0] got,
                              input logic [`BIP_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rsp_ack(input bip_bus_pkg::wb_rsp_t rsp, input string what);
        if (rsp.ack !== 1'b1)
        begin
            timeout_errors++;
            $display("At %0t the host port gave no ack for %s within %0d cycles",
                     $time, what, HOST_TIMEOUT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Host port as Wishbone classic master
    ////////////////////////////////////////////////////////////

    task automatic host_transfer(input logic we, input logic [`BIP_OPERAND_W-1:0] adr,
                                 input logic [`BIP_DATA_W-1:0] wdat,
                                 output logic [`BIP_DATA_W-1:0] rdat);
        int unsigned n;
        @(negedge i_clk);
        i_host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        while (o_host_rsp.ack !== 1'b1 && n < HOST_TIMEOUT)     // Held until granted and acked
        begin
            @(negedge i_clk);
            n++;
        end
        check_rsp_ack(o_host_rsp, $sformatf("%s at %03h", we ? "write" : "read", adr));
        rdat = o_host_rsp.dat;                              // Valid with ack
        i_host_req = '0;                                    // Drop cyc after ack
    endtask

    task automatic host_write(input logic [`BIP_OPERAND_W-1:0] adr,
                              input logic [`BIP_DATA_W-1:0] dat);
        logic [`BIP_DATA_W-1:0] unused;
        host_transfer(1'b1, adr, dat, unused);
        shadow[adr] = dat;
    endtask

    task automatic host_read(input logic [`BIP_OPERAND_W-1:0] adr,
                             output logic [`BIP_DATA_W-1:0] dat);
        host_transfer(1'b0, adr, '0, dat);
    endtask

    ////////////////////////////////////////////////////////////
    // Program handling and reference model
    ////////////////////////////////////////////////////////////

    task automatic load_program();
        foreach (prog_q[i])
            host_write(i[`BIP_OPERAND_W-1:0], prog_q[i]);   // Code from address 0
    endtask

    task automatic preload_data(input logic [`BIP_OPERAND_W-1:0] base, input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++)
        begin
            r = next_random();
            host_write(base + i[`BIP_OPERAND_W-1:0], r[`BIP_DATA_W-1:0]);
        end
    endtask

    // Runs the ISA from PC 0 on the shadow image until HLT
    task automatic model_run();
        logic [`BIP_OPERAND_W-1:0] pc;
        logic [`BIP_OPERAND_W-1:0] opd;
        logic [`BIP_OPCODE_W-1:0]  op;
        logic [`BIP_DATA_W-1:0]    w;
        logic [`BIP_DATA_W-1:0]    imm;
        int unsigned               steps;
        pc    = '0;
        steps = 0;
        forever
        begin
            w   = shadow[pc];
            op  = w[`BIP_DATA_W-1:`BIP_OPERAND_W];
            opd = w[`BIP_OPERAND_W-1:0];
            imm = `BIP_DATA_W'(opd)
                  - (opd[`BIP_OPERAND_W-1] ? (16'd1 << `BIP_OPERAND_W) : 16'd0);  // Signed field
            if (op == bip_isa_pkg::OP_HLT)
                break;
            if (steps >= MODEL_STEPS)
            begin
                timeout_errors++;
                $display("Reference model found no HLT within %0d steps", MODEL_STEPS);
                break;
            end
            case (op)
                bip_isa_pkg::OP_STO:  shadow[opd] = model_acc;
                bip_isa_pkg::OP_LD:   model_acc = shadow[opd];
                bip_isa_pkg::OP_LDI:  model_acc = imm;
                bip_isa_pkg::OP_ADD:  model_acc = model_acc + shadow[opd];   // Mod 2^16
                bip_isa_pkg::OP_ADDI: model_acc = model_acc + imm;
                bip_isa_pkg::OP_SUB:  model_acc = model_acc - shadow[opd];
                bip_isa_pkg::OP_SUBI: model_acc = model_acc - imm;
                default:              ;                                       // Unused code is a NOP
            endcase
            pc = pc + 1'b1;                                 // 11-bit wrap
            steps++;
        end
    endtask

    task automatic run_program();
        int unsigned n;
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        check_bit("o_busy", o_busy, 1'b1);                  // Start taken
        n = 0;
        while (o_busy !== 1'b0 && n < RUN_TIMEOUT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (o_busy !== 1'b0)
        begin
            timeout_errors++;
            $display("At %0t the core was still busy %0d cycles after start", $time, RUN_TIMEOUT);
        end
    endtask

    task automatic readback_region(input logic [`BIP_OPERAND_W-1:0] base, input int count);
        logic [`BIP_OPERAND_W-1:0] adr;
        logic [`BIP_DATA_W-1:0]    d;
        for (int i = 0; i < count; i++)
        begin
            adr = base + i[`BIP_OPERAND_W-1:0];
            host_read(adr, d);
            check_word($sformatf("mem[%03h]", adr), d, shadow[adr]);
        end
    endtask

    // Memory operands stay inside the 64-word data region
    task automatic gen_random_program(input int len);
        logic [31:0]               r;
        logic [`BIP_OPCODE_W-1:0]  op;
        logic [`BIP_OPERAND_W-1:0] opd;
        prog_q.delete();
        for (int i = 0; i < len; i++)
        begin
            r  = next_random();
            op = 5'(1 + r % 7);                             // STO through SUBI so no early HLT
            if (op == bip_isa_pkg::OP_STO || op == bip_isa_pkg::OP_LD ||
                op == bip_isa_pkg::OP_ADD || op == bip_isa_pkg::OP_SUB)
                opd = DATA_BASE + {5'd0, r[20:15]};
            else
                opd = r[26:16];
            prog_q.push_back(encode(op, opd));
        end
        prog_q.push_back(encode(bip_isa_pkg::OP_HLT, '0));
    endtask

    task automatic run_and_check(input int data_words);
        load_program();
        model_run();
        run_program();
        check_word("o_acc", o_acc, model_acc);
        readback_region(DATA_BASE, data_words);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_and_host_access();
        logic [31:0]               r;
        logic [`BIP_OPERAND_W-1:0] adr;
        logic [`BIP_DATA_W-1:0]    d;
        check_bit("o_busy", o_busy, 1'b0);
        for (int i = 0; i < 8; i++)
        begin
            r   = next_random();
            adr = r[`BIP_OPERAND_W-1:0];
            host_write(adr, r[31:16]);
            host_read(adr, d);
            check_word($sformatf("mem[%03h]", adr), d, r[31:16]);
        end
    endtask

    task automatic load_and_store();
        host_write(DATA_BASE + 11'd1, 16'h8123);            // Negative word for LD
        prog_q = '{encode(bip_isa_pkg::OP_LDI, 11'h7FB),    // acc = -5
                   encode(bip_isa_pkg::OP_STO, DATA_BASE),
                   encode(bip_isa_pkg::OP_LD,  DATA_BASE + 11'd1),
                   encode(bip_isa_pkg::OP_STO, DATA_BASE + 11'd2),
                   encode(bip_isa_pkg::OP_HLT, 11'd0)};
        run_and_check(3);
    endtask

    task automatic arithmetic_wrap();
        host_write(DATA_BASE + 11'h10, 16'hFFF0);
        host_write(DATA_BASE + 11'h11, 16'h7000);
        prog_q = '{encode(bip_isa_pkg::OP_LD,   DATA_BASE + 11'h10),
                   encode(bip_isa_pkg::OP_ADD,  DATA_BASE + 11'h11),  // Wraps past 2^16
                   encode(bip_isa_pkg::OP_ADDI, 11'h3FF),
                   encode(bip_isa_pkg::OP_STO,  DATA_BASE + 11'h12),
                   encode(bip_isa_pkg::OP_SUB,  DATA_BASE + 11'h11),
                   encode(bip_isa_pkg::OP_SUBI, 11'h400),             // Minus -1024
                   encode(bip_isa_pkg::OP_STO,  DATA_BASE + 11'h13),
                   encode(bip_isa_pkg::OP_ADDI, 11'h020),
                   encode(bip_isa_pkg::OP_HLT,  11'd0)};
        run_and_check(20);
    endtask

    task automatic halt_and_unused_opcodes();
        logic [31:0] r;
        host_write(DATA_BASE + 11'h20, 16'h5A5A);           // Must survive since STO sits after HLT
        prog_q.delete();
        prog_q.push_back(encode(bip_isa_pkg::OP_ADDI, 11'd100));
        for (int op = 8; op < 32; op++)
        begin
            r = next_random();
            prog_q.push_back(encode(op[`BIP_OPCODE_W-1:0], r[`BIP_OPERAND_W-1:0]));
        end
        prog_q.push_back(encode(bip_isa_pkg::OP_ADDI, 11'd7));
        prog_q.push_back(encode(bip_isa_pkg::OP_HLT, 11'd0));
        prog_q.push_back(encode(bip_isa_pkg::OP_STO, DATA_BASE + 11'h20));
        run_and_check(33);
        repeat (4) @(negedge i_clk);                        // Core stays halted
        check_bit("o_busy", o_busy, 1'b0);
        model_run();                                        // Second start adds again from PC 0
        run_program();
        check_word("o_acc", o_acc, model_acc);
        readback_region(DATA_BASE + 11'h20, 1);
    endtask

    task automatic host_traffic(input int count);
        logic [31:0]               r;
        logic [`BIP_OPERAND_W-1:0] adr;
        logic [`BIP_DATA_W-1:0]    d;
        for (int i = 0; i < count; i++)
        begin
            r   = next_random();
            adr = HOST_BASE + {5'd0, r[5:0]};
            host_write(adr, r[31:16]);
            host_read(adr, d);
            check_word($sformatf("mem[%03h]", adr), d, r[31:16]);
        end
    endtask

    task automatic arbitration_under_load();
        preload_data(DATA_BASE, 64);
        gen_random_program(80);
        load_program();
        model_run();
        fork
            run_program();
            host_traffic(30);                               // Competes with the core
        join
        check_word("o_acc", o_acc, model_acc);
        readback_region(DATA_BASE, 64);
        readback_region(HOST_BASE, 64);
    endtask

    task automatic random_programs();
        for (int p = 0; p < 4; p++)
        begin
            preload_data(DATA_BASE, 64);
            gen_random_program(40);
            run_and_check(64);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and closing report
    ////////////////////////////////////////////////////////////

    initial
    begin
        int unsigned sva_errors;
        i_rst          = 1'b1;
        i_start        = 1'b0;
        i_host_req     = '0;
        model_acc      = '0;                                // Core clears acc on reset
        value_errors   = 0;
        timeout_errors = 0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        reset_and_host_access();
        load_and_store();
        arithmetic_wrap();
        halt_and_unused_opcodes();
        arbitration_under_load();
        random_programs();

        sva_errors = u_bip_top.u_arbiter.u_sva.fail_count;
        $display("Errors: value %0d, timeout %0d, assertion %0d",
                 value_errors, timeout_errors, sva_errors);
        if (value_errors == 0 && timeout_errors == 0 && sva_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bip_top_sva.sv ====
`default_nettype none

module bip_top_sva
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_busy,
    input  wire logic                   i_grant_host,
    input  wire logic                   i_granted_cyc,
    input  wire bip_bus_pkg::wb_rsp_t   i_core_rsp,
    input  wire bip_bus_pkg::wb_rsp_t   i_host_rsp,
    input  wire bip_bus_pkg::wb_req_t   i_mem_req,
    input  wire bip_bus_pkg::wb_rsp_t   i_mem_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;                            // Failed assertions so far

    ////////////////////////////////////////////////////////////
    // Arbiter properties
    ////////////////////////////////////////////////////////////

    // Grant stays put for the whole bus cycle
    a_grant_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_busy && i_granted_cyc) |=> (i_busy && $stable(i_grant_host)))
        else
        begin
            fail_count++;
            $error("Arbiter grant moved during a bus cycle");
        end

    a_no_stray_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_core_rsp.ack && (!i_busy || i_grant_host)) &&
        !(i_host_rsp.ack && (!i_busy || !i_grant_host)))
        else
        begin
            fail_count++;
            $error("Ack reached a master without the grant");
        end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_req.stb |-> i_mem_req.cyc)
        else
        begin
            fail_count++;
            $error("Memory stb high without cyc");
        end

    a_ack_routed: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_rsp.ack |-> (i_busy && (i_grant_host ? i_host_rsp.ack : i_core_rsp.ack)))
        else
        begin
            fail_count++;
            $error("Memory ack not passed to the granted master");
        end

endmodule

bind bip_bus_arbiter bip_top_sva u_sva
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_busy         (busy_q),
    .i_grant_host   (grant_host_q),
    .i_granted_cyc  (granted_cyc),
    .i_core_rsp     (o_core_rsp),
    .i_host_rsp     (o_host_rsp),
    .i_mem_req      (o_mem_req),
    .i_mem_rsp      (i_mem_rsp)
);

`default_nettype wire

// ==== bip_top.sv ====
`default_nettype none

`include "bip_settings.svh"

module bip_top
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_start,
    output logic                        o_busy,
    output logic [`BIP_DATA_W-1:0]      o_acc,
    input  wire bip_bus_pkg::wb_req_t   i_host_req,     // Loader or testbench master
    output bip_bus_pkg::wb_rsp_t        o_host_rsp
);

    bip_bus_pkg::wb_req_t core_req;
    bip_bus_pkg::wb_rsp_t core_rsp;
    bip_bus_pkg::wb_req_t mem_req;
    bip_bus_pkg::wb_rsp_t mem_rsp;

    bip_core u_core
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .o_busy     (o_busy),
        .o_acc      (o_acc),
        .o_req      (core_req),
        .i_rsp      (core_rsp)
    );

    bip_bus_arbiter u_arbiter
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_core_req (core_req),
        .i_host_req (i_host_req),
        .o_core_rsp (core_rsp),
        .o_host_rsp (o_host_rsp),
        .o_mem_req  (mem_req),
        .i_mem_rsp  (mem_rsp)
    );

    bip_memory u_memory
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (mem_req),
        .o_rsp      (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== bip_memory.sv ====
`default_nettype none

`include "bip_settings.svh"

module bip_memory
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire bip_bus_pkg::wb_req_t   i_req,
    output bip_bus_pkg::wb_rsp_t        o_rsp
);

    logic [`BIP_DATA_W-1:0] mem [`BIP_MEM_DEPTH];      // Program and data together
    logic [`BIP_DATA_W-1:0] rdata_q;
    logic                   ack_q;
    logic                   req_new;

    // Transfer not yet acknowledged
    assign req_new = i_req.cyc & i_req.stb & ~ack_q;

    ////////////////////////////////////////////////////////////
    // Slave handshake and array access
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            ack_q <= 1'b0;
        else
            ack_q <= req_new;                           // Single-cycle ack
    end

    always_ff @(posedge i_clk)
    begin
        if (req_new)
        begin
            if (i_req.we)
                mem[i_req.adr] <= i_req.dat;            // Lands with the ack edge
            rdata_q <= mem[i_req.adr];                  // Valid alongside ack
        end
    end

    assign o_rsp.ack = ack_q;
    assign o_rsp.dat = rdata_q;

endmodule

`default_nettype wire

// ==== bip_bus_arbiter.sv ====
`default_nettype none

module bip_bus_arbiter
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire bip_bus_pkg::wb_req_t   i_core_req,
    input  wire bip_bus_pkg::wb_req_t   i_host_req,
    output bip_bus_pkg::wb_rsp_t        o_core_rsp,
    output bip_bus_pkg::wb_rsp_t        o_host_rsp,
    output bip_bus_pkg::wb_req_t        o_mem_req,
    input  wire bip_bus_pkg::wb_rsp_t   i_mem_rsp
);

    logic busy_q;                                       // A grant is held
    logic grant_host_q;                                 // 1 host, 0 core
    logic last_host_q;                                  // Last master served
    logic host_pick;
    logic granted_cyc;

    // Host wins alone, or when both ask and core went last
    assign host_pick   = i_host_req.cyc & (~i_core_req.cyc | ~last_host_q);
    assign granted_cyc = grant_host_q ? i_host_req.cyc : i_core_req.cyc;

    ////////////////////////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            busy_q       <= 1'b0;
            grant_host_q <= 1'b0;
            last_host_q  <= 1'b1;                       // Core first on a tie
        end
        else if (!busy_q)
        begin
            if (i_core_req.cyc | i_host_req.cyc)
            begin
                busy_q       <= 1'b1;
                grant_host_q <= host_pick;
                last_host_q  <= host_pick;
            end
        end
        else if (!granted_cyc)
        begin
            busy_q <= 1'b0;                             // Bus cycle over
        end
    end

    // Routing, combinational from the grant
    always_comb
    begin
        o_mem_req  = '0;
        o_core_rsp = '0;                                // Ack low unless granted
        o_host_rsp = '0;
        if (busy_q)
        begin
            if (grant_host_q)
            begin
                o_mem_req  = i_host_req;
                o_host_rsp = i_mem_rsp;
            end
            else
            begin
                o_mem_req  = i_core_req;
                o_core_rsp = i_mem_rsp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bip_core.sv ====
`default_nettype none

`include "bip_settings.svh"

module bip_core
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_start,    // One-cycle pulse
    output logic                        o_busy,
    output logic [`BIP_DATA_W-1:0]      o_acc,
    output bip_bus_pkg::wb_req_t        o_req,
    input  wire bip_bus_pkg::wb_rsp_t   i_rsp
);

    typedef enum logic [2:0] {
        S_IDLE,                                         // Waiting for start
        S_FETCH,                                        // Read word at PC
        S_EXEC,                                         // Decode settles
        S_DATA,                                         // Operand load or store
        S_WB                                            // Update acc and PC
    } state_e;

    state_e                         state_q;
    logic [`BIP_OPERAND_W-1:0]      pc_q;
    logic [`BIP_DATA_W-1:0]         acc_q;
    bip_isa_pkg::mem_word_u         ir_q;               // Fetched word
    bip_isa_pkg::mem_word_u         mdr_q;              // Data cycle word
    bip_isa_pkg::ctrl_t             ctrl;
    logic                           need_data;
    logic [`BIP_DATA_W-1:0]         imm_sext;
    logic [`BIP_DATA_W-1:0]         alu_b;
    logic [`BIP_DATA_W-1:0]         alu_res;
    logic [`BIP_DATA_W-1:0]         acc_next;

    instruction_decoder u_decoder
    (
        .i_opcode   (ir_q.instr.opcode),
        .o_ctrl     (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    assign need_data = ctrl.rd_ram | ctrl.wr_ram;      // Memory-operand opcodes only
    assign imm_sext  = {{(`BIP_DATA_W-`BIP_OPERAND_W){ir_q.instr.operand[`BIP_OPERAND_W-1]}},
                        ir_q.instr.operand};            // 11 to 16 bits, signed
    assign alu_b     = (ctrl.sel_b == bip_isa_pkg::SEL_B_IMM) ? imm_sext : mdr_q.data;

    always_comb
    begin
        case (ctrl.alu_op)
            bip_isa_pkg::ALU_ADD: alu_res = acc_q + alu_b;     // Wraps mod 2^16
            bip_isa_pkg::ALU_SUB: alu_res = acc_q - alu_b;
            default:              alu_res = alu_b;             // Pass
        endcase
    end

    always_comb
    begin
        case (ctrl.sel_a)
            bip_isa_pkg::SEL_A_IMM: acc_next = imm_sext;
            bip_isa_pkg::SEL_A_ALU: acc_next = alu_res;
            default:                acc_next = mdr_q.data;     // Load
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Bus master, request straight from state
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        o_req = '0;
        case (state_q)
            S_FETCH:
            begin
                o_req.cyc = 1'b1;
                o_req.stb = 1'b1;
                o_req.adr = pc_q;                       // Instruction read
            end
            S_DATA:
            begin
                o_req.cyc = 1'b1;
                o_req.stb = 1'b1;
                o_req.we  = ctrl.wr_ram;                // STO writes, others read
                o_req.adr = ir_q.instr.operand;
                o_req.dat = acc_q;
            end
            default:
            begin
                o_req = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state_q <= S_IDLE;
            pc_q    <= '0;
            acc_q   <= '0;
        end
        else
        begin
            case (state_q)
                S_IDLE:
                begin
                    if (i_start)
                    begin
                        pc_q    <= '0;                  // Program always starts at 0
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH:
                begin
                    if (i_rsp.ack)
                        state_q <= S_EXEC;
                end
                S_EXEC:
                begin
                    if (ctrl.halt)
                        state_q <= S_IDLE;              // Busy drops, PC held
                    else if (need_data)
                        state_q <= S_DATA;
                    else
                        state_q <= S_WB;
                end
                S_DATA:
                begin
                    if (i_rsp.ack)
                        state_q <= S_WB;
                end
                S_WB:
                begin
                    if (ctrl.wr_acc)
                        acc_q <= acc_next;
                    if (ctrl.wr_pc)
                        pc_q <= pc_q + 1'b1;            // 11-bit wrap
                    state_q <= S_FETCH;
                end
                default:
                begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Instruction and operand words, captured on ack
    always_ff @(posedge i_clk)
    begin
        if (state_q == S_FETCH && i_rsp.ack)
            ir_q <= bip_isa_pkg::mem_word_u'(i_rsp.dat);
        if (state_q == S_DATA && i_rsp.ack)
            mdr_q <= bip_isa_pkg::mem_word_u'(i_rsp.dat);
    end

    assign o_busy = (state_q != S_IDLE);
    assign o_acc  = acc_q;

endmodule

`default_nettype wire

// ==== instruction_decoder.sv ====
`default_nettype none

module instruction_decoder
(
    input  wire bip_isa_pkg::opcode_e   i_opcode,
    output bip_isa_pkg::ctrl_t          o_ctrl
);

    ////////////////////////////////////////////////////////////
    // Opcode to control word
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        o_ctrl = '0;                                            // All enables off, selects at 0
        case (i_opcode)
            bip_isa_pkg::OP_HLT:
            begin
                o_ctrl.halt = 1'b1;                             // PC frozen, nothing written
            end
            bip_isa_pkg::OP_STO:
            begin
                o_ctrl.wr_pc  = 1'b1;
                o_ctrl.wr_ram = 1'b1;                           // Acc goes out on the bus
            end
            bip_isa_pkg::OP_LD:
            begin
                o_ctrl.wr_pc  = 1'b1;
                o_ctrl.sel_a  = bip_isa_pkg::SEL_A_MEM;         // Acc from memory
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.rd_ram = 1'b1;
            end
            bip_isa_pkg::OP_LDI:
            begin
                o_ctrl.wr_pc  = 1'b1;
                o_ctrl.sel_a  = bip_isa_pkg::SEL_A_IMM;         // Acc from operand
                o_ctrl.wr_acc = 1'b1;
            end
            bip_isa_pkg::OP_ADD, bip_isa_pkg::OP_SUB:
            begin
                o_ctrl.wr_pc  = 1'b1;
                o_ctrl.sel_a  = bip_isa_pkg::SEL_A_ALU;
                o_ctrl.sel_b  = bip_isa_pkg::SEL_B_MEM;         // Second operand read first
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.alu_op = (i_opcode == bip_isa_pkg::OP_SUB) ? bip_isa_pkg::ALU_SUB
                                                                   : bip_isa_pkg::ALU_ADD;
                o_ctrl.rd_ram = 1'b1;
            end
            bip_isa_pkg::OP_ADDI, bip_isa_pkg::OP_SUBI:
            begin
                o_ctrl.wr_pc  = 1'b1;
                o_ctrl.sel_a  = bip_isa_pkg::SEL_A_ALU;
                o_ctrl.sel_b  = bip_isa_pkg::SEL_B_IMM;         // No data cycle
                o_ctrl.wr_acc = 1'b1;
                o_ctrl.alu_op = (i_opcode == bip_isa_pkg::OP_SUBI) ? bip_isa_pkg::ALU_SUB
                                                                    : bip_isa_pkg::ALU_ADD;
            end
            default:
            begin
                o_ctrl.wr_pc = 1'b1;                            // Unused code, plain NOP
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== bip_bus_pkg.sv ====
`default_nettype none

`include "bip_settings.svh"

package bip_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Wishbone classic, no error or retry
    ////////////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                       cyc;    // Bus cycle in progress
        logic                       stb;    // Transfer valid
        logic                       we;     // Write when high
        logic [`BIP_OPERAND_W-1:0]  adr;    // Word address
        logic [`BIP_DATA_W-1:0]     dat;    // Write data
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                       ack;    // One cycle per transfer
        logic [`BIP_DATA_W-1:0]     dat;    // Read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== bip_isa_pkg.sv ====
`default_nettype none

`include "bip_settings.svh"

package bip_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes and control selects
    ////////////////////////////////////////////////////////////

    typedef enum logic [`BIP_OPCODE_W-1:0] {
        OP_HLT  = 0,                        // Stop, clear busy
        OP_STO  = 1,                        // mem[op] = acc
        OP_LD   = 2,                        // acc = mem[op]
        OP_LDI  = 3,                        // acc = sext(op)
        OP_ADD  = 4,                        // acc += mem[op]
        OP_ADDI = 5,                        // acc += sext(op)
        OP_SUB  = 6,                        // acc -= mem[op]
        OP_SUBI = 7                         // acc -= sext(op)
    } opcode_e;

    typedef enum logic [1:0] {
        SEL_A_MEM = 2'd0,                   // Loaded word
        SEL_A_IMM = 2'd1,                   // Extended operand
        SEL_A_ALU = 2'd2                    // Adder result
    } sel_a_e;

    typedef enum logic {
        SEL_B_MEM = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_e;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2
    } alu_op_e;

    typedef struct packed {
        logic    wr_pc;                     // Advance PC in writeback
        sel_a_e  sel_a;
        sel_b_e  sel_b;
        logic    wr_acc;
        alu_op_e alu_op;
        logic    wr_ram;                    // Data cycle is a write
        logic    rd_ram;                    // Data cycle is a read
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        opcode_e                    opcode;
        logic [`BIP_OPERAND_W-1:0]  operand; // Address or immediate
    } instr_t;

    // Same word seen as code or as data
    typedef union packed {
        instr_t                         instr;
        logic signed [`BIP_DATA_W-1:0]  data;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== bip_settings.svh ====
`ifndef BIP_SETTINGS_SVH
`define BIP_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath and memory sizing
////////////////////////////////////////////////////////////

// Accumulator and memory word width
`define BIP_DATA_W      16

// Instruction fields, opcode on top
`define BIP_OPCODE_W    5
`define BIP_OPERAND_W   11

// Word count, one entry per operand address
`define BIP_MEM_DEPTH   2048

`endif
